/* src.f */
common/decode_pkg.sv
decoder/imm_gen.sv
decoder/priv_decoder.sv
decoder/opcode_decoder.sv
src/decode_reg.sv
src/decode_stage.sv
dv/tb_clock_gen.sv
dv/decode_stage_tb.sv

/* Makefile */
XLEN      ?= 64
SEED      ?= 93843
LOG       ?= sim.log
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
TOP       ?= decode_stage_tb

VFLAGS ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: XLEN=$(XLEN) SEED=$(SEED) LOG=$(LOG) VERILATOR=$(VERILATOR)"

test:
	$(VERILATOR) $(VFLAGS) -f src.f --top-module $(TOP) \
		-GXLEN=$(XLEN) -GSEED=$(SEED) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/decode_stage_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage_tb import decode_pkg::*; #(
    parameter int          XLEN = 64,
    parameter int unsigned SEED = 93843
);

    localparam int N_ALU   = 400;
    localparam int N_MEM   = 200;
    localparam int N_CTRL  = 200;
    localparam int N_SYS   = 3 * 8 * 6 + 14 + 64;
    localparam int N_FEXC  = 100;
    localparam int N_PIPE  = 300;
    localparam int N_TOTAL = N_ALU + N_MEM + N_CTRL + N_SYS + N_FEXC + N_PIPE;

    // ALU group first, then memory, control flow, MISC_MEM and SYSTEM
    localparam logic [6:0] OPCODES [13] = '{
        OPCODE_OP_IMM, OPCODE_OP_IMM_32, OPCODE_OP, OPCODE_OP_32, OPCODE_LOAD, OPCODE_STORE,
        OPCODE_BRANCH, OPCODE_JAL, OPCODE_JALR, OPCODE_LUI, OPCODE_AUIPC, OPCODE_MISC_MEM,
        OPCODE_SYSTEM
    };

    localparam logic [31:0] MISC_WORDS [14] = '{
        32'h0000100F, 32'h0FF0000F, 32'h0000200F, 32'h30029073, 32'h3002A073, 32'h30005073,
        32'h0000202F, 32'h1000202F, 32'h02208033, 32'h0220C033, 32'h0220803B, 32'h00004501,
        32'h00000000, 32'hFFFFFFFF
    };

    logic           clk;
    logic           rst;
    logic           in_valid;
    fetched_instr_t fetched;
    prv_e           prv;
    status_t        status;
    logic           out_valid;
    decoded_instr_t decoded;

    decoded_instr_t want_q[$];
    int             due_q[$];
    string          name_q[$];
    string          test_name;
    int             cycle;
    int             checks;
    int             errors;
    int             checks0;
    int             errors0;

    tb_clock_gen #(
        .PERIOD_NS (100)
    ) i_tb_clock_gen (
        .clk (clk)
    );

    decode_stage #(
        .XLEN (XLEN)
    ) i_decode_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .fetched   (fetched),
        .prv       (prv),
        .status    (status),
        .out_valid (out_valid),
        .decoded   (decoded)
    );

    function automatic logic [31:0] imm_i(input logic [31:0] w);
        return 32'($signed(w[31:20]));
    endfunction

    function automatic logic [31:0] imm_s(input logic [31:0] w);
        return 32'($signed({w[31:25], w[11:7]}));
    endfunction

    function automatic logic [31:0] imm_b(input logic [31:0] w);
        return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
    endfunction

    function automatic logic [31:0] imm_j(input logic [31:0] w);
        return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
    endfunction

    // Cause and tval only carry meaning while the exception is valid
    function automatic decoded_instr_t normalize(input decoded_instr_t d);
        if (!d.exception.valid) begin
            d.exception.interrupt = 1'b0;
            d.exception.cause = '0;
            d.exception.tval = '0;
        end
        return d;
    endfunction

    function automatic decoded_instr_t ref_decode(input fetched_instr_t f, input prv_e p,
                                                  input status_t st);
        decoded_instr_t r;
        logic [31:0]    w;
        logic [6:0]     opc;
        logic [6:0]     f7;
        logic [2:0]     f3;
        logic           word_op;
        logic           reg_form;
        logic           sys_ok;
        logic           ill;
        logic [3:0]     cause;
        logic           tval_zero;
        w = f.instr;
        opc = w[6:0];
        f7 = w[31:25];
        f3 = w[14:12];
        word_op = opc == OPCODE_OP_IMM_32 || opc == OPCODE_OP_32;
        reg_form = opc == OPCODE_OP || opc == OPCODE_OP_32;
        sys_ok = f3 == 3'd0 && w[19:15] == 5'd0;
        ill = 1'b0;
        cause = CAUSE_ILLEGAL;
        tval_zero = 1'b0;
        r = '0;
        r.pc = f.pc;
        // Only register-register ALU ops feed rs2 into the adder
        r.adder_use_imm = !reg_form;
        case (opc)
            OPCODE_OP_IMM, OPCODE_OP_IMM_32, OPCODE_OP, OPCODE_OP_32: begin
                r.rs1 = w[19:15];
                r.rd = w[11:7];
                r.is_32 = word_op;
                if (reg_form) begin
                    r.rs2 = w[24:20];
                end else begin
                    r.use_imm = 1'b1;
                    r.immediate = imm_i(w);
                end
                case (f3)
                    3'd0: begin
                        if (reg_form && f7 == 7'h20) begin
                            r.alu_op = SUB;
                        end else begin
                            r.alu_op = ADD;
                        end
                    end
                    3'd2: begin
                        r.alu_op = SCC;
                        r.condition = CC_LT;
                    end
                    3'd3: begin
                        r.alu_op = SCC;
                        r.condition = CC_LTU;
                    end
                    3'd4: r.alu_op = L_XOR;
                    3'd6: r.alu_op = L_OR;
                    3'd7: r.alu_op = L_AND;
                    default: begin
                        r.alu_op = SHIFT;
                        r.shift_left = f3 == 3'd1;
                        r.shift_arith = f3 == 3'd5 && f7[5];
                    end
                endcase
                if (word_op && (XLEN == 32 || !(f3 inside {3'd0, 3'd1, 3'd5}))) ill = 1'b1;
                if (reg_form) begin
                    if (!(f7 == 7'h00 || (f7 == 7'h20 && f3 inside {3'd0, 3'd5}))) begin
                        ill = 1'b1;
                        r.alu_op = ADD;
                        r.condition = CC_FALSE;
                        r.shift_left = 1'b0;
                        r.shift_arith = 1'b0;
                    end
                end else if (f3 inside {3'd1, 3'd5}) begin
                    if (!(f7[6:1] == 6'd0 || (f3 == 3'd5 && f7[6:1] == 6'b010000))) ill = 1'b1;
                    // shamt bit 5 is only legal for full-width shifts on RV64
                    if ((XLEN == 32 || word_op) && f7[0]) ill = 1'b1;
                end
            end
            OPCODE_LOAD: begin
                r.op_type = MEM;
                r.rs1 = w[19:15];
                r.rd = w[11:7];
                r.use_imm = 1'b1;
                r.mem_op = MEM_LOAD;
                r.mem_size = f3[1:0];
                r.mem_zeroext = f3[2];
                r.immediate = imm_i(w);
                if (XLEN == 64) ill = f3 == 3'd7;
                else ill = f3[1:0] == 2'd3 || f3 == 3'd6;
            end
            OPCODE_STORE: begin
                r.op_type = MEM;
                r.rs1 = w[19:15];
                r.rs2 = w[24:20];
                r.use_imm = 1'b1;
                r.mem_op = MEM_STORE;
                r.mem_size = f3[1:0];
                r.immediate = imm_s(w);
                ill = f3[2] || (XLEN == 32 && f3[1:0] == 2'd3);
            end
            OPCODE_MISC_MEM: begin
                if (f3 == 3'd1) begin
                    r.op_type = SYSTEM;
                    r.sys_op = FENCE_I;
                end else if (f3 != 3'd0) begin
                    ill = 1'b1;
                end
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                r.rd = w[11:7];
                r.use_imm = 1'b1;
                r.use_pc = opc == OPCODE_AUIPC;
                r.immediate = {w[31:12], 12'h000};
            end
            OPCODE_BRANCH: begin
                r.op_type = BRANCH;
                r.rs1 = w[19:15];
                r.rs2 = w[24:20];
                r.use_pc = 1'b1;
                r.immediate = imm_b(w);
                case (f3)
                    3'd0: r.condition = CC_EQ;
                    3'd1: r.condition = CC_NE;
                    3'd4: r.condition = CC_LT;
                    3'd5: r.condition = CC_GE;
                    3'd6: r.condition = CC_LTU;
                    3'd7: r.condition = CC_GEU;
                    default: ill = 1'b1;
                endcase
            end
            OPCODE_JALR: begin
                r.op_type = BRANCH;
                r.rs1 = w[19:15];
                r.rd = w[11:7];
                r.use_imm = 1'b1;
                r.condition = CC_TRUE;
                r.immediate = imm_i(w);
                ill = f3 != 3'd0;
            end
            OPCODE_JAL: begin
                r.op_type = BRANCH;
                r.rd = w[11:7];
                r.use_pc = 1'b1;
                r.condition = CC_TRUE;
                r.immediate = imm_j(w);
            end
            OPCODE_SYSTEM: begin
                ill = 1'b1;
                if (sys_ok && w[31:20] == 12'h000) begin
                    cause = CAUSE_ECALL_BASE + {2'b00, p};
                    tval_zero = 1'b1;
                end else if (sys_ok && w[31:20] == 12'h001) begin
                    cause = CAUSE_BREAKPOINT;
                    tval_zero = 1'b1;
                end else if (sys_ok && w[31:20] == 12'h302) begin
                    r.op_type = SYSTEM;
                    r.sys_op = ERET;
                    ill = p != PRV_M;
                end else if (sys_ok && w[31:20] == 12'h102) begin
                    r.op_type = SYSTEM;
                    r.sys_op = ERET;
                    ill = !(p == PRV_M || (p == PRV_S && !st.tsr));
                end else if (sys_ok && w[31:20] == 12'h105) begin
                    r.op_type = SYSTEM;
                    r.sys_op = WFI;
                    ill = !(p == PRV_M || (p == PRV_S && !st.tw));
                end else if (f3 == 3'd0 && f7 == 7'b0001001) begin
                    r.op_type = SYSTEM;
                    r.sys_op = SFENCE_VMA;
                    r.rs1 = w[19:15];
                    r.rs2 = w[24:20];
                    ill = !(p == PRV_M || (p == PRV_S && !st.tvm));
                end
            end
            default: ill = 1'b1;
        endcase
        r.exception.valid = ill;
        if (ill) begin
            r.exception.cause = cause;
            r.exception.tval = tval_zero ? 64'd0 : {32'd0, w};
        end
        if (f.exception.valid) r.exception = f.exception;
        return r;
    endfunction

    function automatic prv_e prv_of(input int i);
        case (i)
            0: return PRV_U;
            1: return PRV_S;
            default: return PRV_M;
        endcase
    endfunction

    function automatic logic [31:0] word_with(input int lo, input int hi);
        logic [31:0] w;
        w = $urandom;
        w[6:0] = OPCODES[4'($urandom_range(hi, lo))];
        return w;
    endfunction

    task automatic issue(input logic [31:0] word, input prv_e p, input status_t st,
                         input exception_t fexc);
        fetched_instr_t f;
        f.pc = {$urandom, $urandom};
        f.instr = word;
        f.exception = fexc;
        @(posedge clk);
        in_valid <= 1'b1;
        fetched <= f;
        prv <= p;
        status <= st;
        want_q.push_back(normalize(ref_decode(f, p, st)));
        // Sampled on the next edge, visible at the negedge after it
        due_q.push_back(cycle + 2);
        name_q.push_back(test_name);
    endtask

    task automatic issue_random(input logic [31:0] word);
        issue(word, prv_of($urandom_range(2, 0)), status_t'(3'($urandom)), '0);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        checks0 = checks;
        errors0 = errors;
    endtask

    task automatic close_test();
        int i;
        idle(1);
        for (i = 0; i < 10 && want_q.size() != 0; i++) begin
            @(negedge clk);
        end
        assert (want_q.size() == 0) else begin
            $display("ERROR: %s left %0d results that never came out", test_name,
                     want_q.size());
            errors++;
            want_q.delete();
            due_q.delete();
            name_q.delete();
        end
        $display("test %s: %0d checks, %0d errors", test_name, checks - checks0,
                 errors - errors0);
    endtask

    initial begin : compare
        decoded_instr_t want;
        decoded_instr_t got;
        string          name;
        int             due;
        forever begin
            @(negedge clk);
            cycle++;
            if (out_valid) begin
                assert (want_q.size() != 0) else begin
                    $display("ERROR: out_valid high at cycle %0d with nothing issued", cycle);
                    errors++;
                end
                if (want_q.size() != 0) begin
                    want = want_q.pop_front();
                    due = due_q.pop_front();
                    name = name_q.pop_front();
                    got = normalize(decoded);
                    checks++;
                    assert (got == want) else begin
                        $display("CHECK FAILED %s: expected %h actual %h", name, want, got);
                        errors++;
                    end
                    assert (cycle == due) else begin
                        $display("CHECK FAILED %s latency: expected cycle %0d actual %0d",
                                 name, due, cycle);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        repeat (4 * N_TOTAL + 100) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles", 4 * N_TOTAL + 100);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        exception_t  fexc;
        logic [31:0] w;
        int          i;
        int          pi;
        int          si;
        int          k;
        void'($urandom(SEED));
        // Strobe stays high through reset to show that reset wins
        rst <= 1'b1;
        in_valid <= 1'b1;
        fetched <= '0;
        prv <= PRV_M;
        status <= '0;

        start_test("reset");
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        in_valid <= 1'b0;
        @(negedge clk);
        checks++;
        assert (out_valid == 1'b0) else begin
            $display("CHECK FAILED reset: expected out_valid 0 actual %0d", out_valid);
            errors++;
        end
        close_test();

        start_test("alu");
        for (i = 0; i < N_ALU; i++) begin
            w = word_with(0, 3);
            case ($urandom_range(3, 0))
                0: w[31:25] = 7'h00;
                1: w[31:25] = 7'h20;
                2: w[31:25] = 7'h01;
                default: w[31:25] = 7'h21;
            endcase
            issue_random(w);
        end
        close_test();

        start_test("memory");
        for (i = 0; i < N_MEM; i++) issue_random(word_with(4, 5));
        close_test();

        start_test("control");
        for (i = 0; i < N_CTRL; i++) issue_random(word_with(6, 10));
        close_test();

        start_test("system");
        for (pi = 0; pi < 3; pi++) begin
            for (si = 0; si < 8; si++) begin
                for (k = 0; k < 6; k++) begin
                    case (k)
                        0: w = 32'h00000073;
                        1: w = 32'h00100073;
                        2: w = 32'h30200073;
                        3: w = 32'h10200073;
                        4: w = 32'h10500073;
                        default: w = {7'b0001001, 5'($urandom), 5'($urandom), 15'h0073};
                    endcase
                    issue(w, prv_of(pi), status_t'(3'(si)), '0);
                end
            end
        end
        for (i = 0; i < 14; i++) issue_random(MISC_WORDS[i]);
        for (i = 0; i < 64; i++) begin
            w = word_with(12, 12);
            if ($urandom_range(1, 0) != 0) w[14:12] = 3'd0;
            if ($urandom_range(1, 0) != 0) w[19:15] = 5'd0;
            issue_random(w);
        end
        close_test();

        start_test("fetch_exc");
        for (i = 0; i < N_FEXC; i++) begin
            fexc = {1'b1, 1'($urandom), 4'($urandom), $urandom, $urandom};
            issue($urandom, prv_of($urandom_range(2, 0)), status_t'(3'($urandom)), fexc);
        end
        close_test();

        start_test("pipeline");
        for (i = 0; i < N_PIPE; i++) begin
            w = ($urandom_range(3, 0) != 0) ? word_with(0, 12) : $urandom;
            fexc = '0;
            if ($urandom_range(7, 0) == 0) begin
                fexc = {1'b1, 1'($urandom), 4'($urandom), $urandom, $urandom};
            end
            issue(w, prv_of($urandom_range(2, 0)), status_t'(3'($urandom)), fexc);
            if ($urandom_range(1, 0) != 0) idle($urandom_range(2, 1));
        end
        close_test();

        $display("done: 7 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage import decode_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  fetched_instr_t fetched,
    input  prv_e           prv,
    input  status_t        status,
    output logic           out_valid,
    output decoded_instr_t decoded
);

    // Combinational decode result ahead of the register
    decoded_instr_t decoded_comb;

    opcode_decoder #(
        .XLEN (XLEN)
    ) i_opcode_decoder (
        .fetched (fetched),
        .prv     (prv),
        .status  (status),
        .decoded (decoded_comb)
    );

    decode_reg i_decode_reg (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .d         (decoded_comb),
        .out_valid (out_valid),
        .q         (decoded)
    );

endmodule

`default_nettype wire

/* src/decode_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_reg import decode_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  decoded_instr_t d,
    output logic           out_valid,
    output decoded_instr_t q
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Payload holds its last value between strobes
    always_ff @(posedge clk) begin
        if (in_valid) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* decoder/opcode_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module opcode_decoder import decode_pkg::*; #(
    parameter int XLEN = 64
) (
    input  fetched_instr_t fetched,
    input  prv_e           prv,
    input  status_t        status,
    output decoded_instr_t decoded
);

    logic [31:0]    instr;
    logic [6:0]     funct7;
    logic [4:0]     rs2;
    logic [4:0]     rs1;
    logic [2:0]     funct3;
    logic [4:0]     rd;
    logic [6:0]     opcode;
    logic           exc_raise;
    imm_fmt_e       imm_fmt;
    logic [31:0]    imm;
    priv_decode_t   priv;
    decoded_instr_t base;

    assign instr  = fetched.instr;
    assign funct7 = instr[31:25];
    assign rs2    = instr[24:20];
    assign rs1    = instr[19:15];
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign opcode = instr[6:0];

    priv_decoder i_priv_decoder (
        .sys_bits (instr[31:20]),
        .funct3   (funct3),
        .rs1      (rs1),
        .prv      (prv),
        .status   (status),
        .result   (priv)
    );

    imm_gen i_imm_gen (
        .instr (instr),
        .fmt   (imm_fmt),
        .imm   (imm)
    );

    always_comb begin
        base = '0;
        base.pc = fetched.pc;
        base.adder_use_imm = 1'b1;
        base.exception.cause = CAUSE_ILLEGAL;
        base.exception.tval = {32'b0, instr};
        imm_fmt = IMM_ZERO;
        exc_raise = 1'b0;

        case (opcode)
            OPCODE_LOAD: begin
                base.op_type = MEM;
                base.rs1 = rs1;
                base.rd = rd;
                base.use_imm = 1'b1;
                base.mem_op = MEM_LOAD;
                base.mem_size = funct3[1:0];
                base.mem_zeroext = funct3[2];
                imm_fmt = IMM_I;
                if (XLEN == 32 && (funct3[1:0] == 2'b11 || funct3 == 3'b110)) exc_raise = 1'b1;
                if (XLEN == 64 && funct3 == 3'b111) exc_raise = 1'b1;
            end
            OPCODE_STORE: begin
                base.op_type = MEM;
                base.rs1 = rs1;
                base.rs2 = rs2;
                base.use_imm = 1'b1;
                base.mem_op = MEM_STORE;
                base.mem_size = funct3[1:0];
                imm_fmt = IMM_S;
                if (funct3[2]) exc_raise = 1'b1;
                if (XLEN == 32 && funct3[1:0] == 2'b11) exc_raise = 1'b1;
            end
            OPCODE_MISC_MEM: begin
                // FENCE falls through as a no-op
                if (funct3 == 3'b001) begin
                    base.op_type = SYSTEM;
                    base.sys_op = FENCE_I;
                end else if (funct3 != 3'b000) begin
                    exc_raise = 1'b1;
                end
            end
            OPCODE_OP_IMM, OPCODE_OP_IMM_32: begin
                base.rs1 = rs1;
                base.rd = rd;
                base.use_imm = 1'b1;
                base.is_32 = opcode[3];
                imm_fmt = IMM_I;
                if (base.is_32 && XLEN == 32) exc_raise = 1'b1;
                if (base.is_32 && !(funct3 inside {3'b000, 3'b001, 3'b101})) exc_raise = 1'b1;
                case (funct3)
                    3'b000: base.alu_op = ADD;
                    3'b010: begin
                        base.alu_op = SCC;
                        base.condition = CC_LT;
                    end
                    3'b011: begin
                        base.alu_op = SCC;
                        base.condition = CC_LTU;
                    end
                    3'b100: base.alu_op = L_XOR;
                    3'b110: base.alu_op = L_OR;
                    3'b111: base.alu_op = L_AND;
                    default: begin
                        base.alu_op = SHIFT;
                        base.shift_left = !funct3[2];
                        base.shift_arith = funct3[2] & funct7[5];
                        if (!(funct7[6:1] == 6'b0 || (funct3[2] && funct7[6:1] == 6'b010000)))
                            exc_raise = 1'b1;
                        // shamt[5] only exists for full-width shifts on RV64
                        if ((XLEN == 32 || base.is_32) && funct7[0]) exc_raise = 1'b1;
                    end
                endcase
            end
            OPCODE_OP, OPCODE_OP_32: begin
                base.rs1 = rs1;
                base.rs2 = rs2;
                base.rd = rd;
                base.adder_use_imm = 1'b0;
                base.is_32 = opcode[3];
                if (base.is_32 && XLEN == 32) exc_raise = 1'b1;
                if (base.is_32 && !(funct3 inside {3'b000, 3'b001, 3'b101})) exc_raise = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: base.alu_op = ADD;
                    {7'b0100000, 3'b000}: base.alu_op = SUB;
                    {7'b0000000, 3'b010}: begin
                        base.alu_op = SCC;
                        base.condition = CC_LT;
                    end
                    {7'b0000000, 3'b011}: begin
                        base.alu_op = SCC;
                        base.condition = CC_LTU;
                    end
                    {7'b0000000, 3'b100}: base.alu_op = L_XOR;
                    {7'b0000000, 3'b110}: base.alu_op = L_OR;
                    {7'b0000000, 3'b111}: base.alu_op = L_AND;
                    {7'b0000000, 3'b001}, {7'b0000000, 3'b101}, {7'b0100000, 3'b101}: begin
                        base.alu_op = SHIFT;
                        base.shift_left = !funct3[2];
                        base.shift_arith = funct7[5];
                    end
                    default: exc_raise = 1'b1;
                endcase
            end
            OPCODE_AUIPC, OPCODE_LUI: begin
                base.rd = rd;
                base.use_imm = 1'b1;
                base.use_pc = !opcode[5];
                imm_fmt = IMM_U;
            end
            OPCODE_BRANCH: begin
                base.op_type = BRANCH;
                base.rs1 = rs1;
                base.rs2 = rs2;
                base.use_pc = 1'b1;
                imm_fmt = IMM_B;
                case (funct3)
                    3'b000: base.condition = CC_EQ;
                    3'b001: base.condition = CC_NE;
                    3'b100: base.condition = CC_LT;
                    3'b101: base.condition = CC_GE;
                    3'b110: base.condition = CC_LTU;
                    3'b111: base.condition = CC_GEU;
                    default: exc_raise = 1'b1;
                endcase
            end
            OPCODE_JALR: begin
                base.op_type = BRANCH;
                base.rs1 = rs1;
                base.rd = rd;
                base.use_imm = 1'b1;
                base.condition = CC_TRUE;
                imm_fmt = IMM_I;
                if (funct3 != 3'b000) exc_raise = 1'b1;
            end
            OPCODE_JAL: begin
                base.op_type = BRANCH;
                base.rd = rd;
                base.use_pc = 1'b1;
                base.condition = CC_TRUE;
                imm_fmt = IMM_J;
            end
            OPCODE_SYSTEM: begin
                base.op_type = priv.is_sys ? SYSTEM : ALU;
                base.sys_op = priv.sys_op;
                if (priv.uses_rs) begin
                    base.rs1 = rs1;
                    base.rs2 = rs2;
                end
                base.exception.cause = priv.cause;
                if (priv.tval_zero) base.exception.tval = '0;
                exc_raise = priv.exc_valid;
            end
            // Compressed, AMO and unknown opcodes
            default: exc_raise = 1'b1;
        endcase

        base.exception.valid = exc_raise;
    end

    // Fetch faults take priority over anything found in the word
    always_comb begin
        decoded = base;
        decoded.immediate = imm;
        if (fetched.exception.valid) decoded.exception = fetched.exception;
    end

endmodule

`default_nettype wire

/* decoder/priv_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module priv_decoder import decode_pkg::*; (
    input  logic [11:0]  sys_bits,
    input  logic [2:0]   funct3,
    input  logic [4:0]   rs1,
    input  prv_e         prv,
    input  status_t      status,
    output priv_decode_t result
);

    logic m_mode;
    logic s_mode;

    assign m_mode = prv == PRV_M;
    assign s_mode = prv == PRV_S;

    always_comb begin
        result = '0;
        result.exc_valid = 1'b1;
        result.cause = CAUSE_ILLEGAL;

        // Nonzero funct3 is CSR space, which is not decoded here
        if (funct3 == 3'b000 && (rs1 == 5'd0 || sys_bits[11:5] == 7'b0001001)) begin
            casez (sys_bits)
                12'b0000000_00000: begin
                    result.cause = CAUSE_ECALL_BASE + {2'b00, prv};
                    result.tval_zero = 1'b1;
                end
                12'b0000000_00001: begin
                    result.cause = CAUSE_BREAKPOINT;
                    result.tval_zero = 1'b1;
                end
                12'b0011000_00010: begin
                    result.is_sys = 1'b1;
                    result.sys_op = ERET;
                    result.exc_valid = !m_mode;
                end
                12'b0001000_00010: begin
                    result.is_sys = 1'b1;
                    result.sys_op = ERET;
                    result.exc_valid = !(m_mode || (s_mode && !status.tsr));
                end
                12'b0001000_00101: begin
                    result.is_sys = 1'b1;
                    result.sys_op = WFI;
                    result.exc_valid = !(m_mode || (s_mode && !status.tw));
                end
                // rs2 is the ASID operand
                12'b0001001_?????: begin
                    result.is_sys = 1'b1;
                    result.sys_op = SFENCE_VMA;
                    result.uses_rs = 1'b1;
                    result.exc_valid = !(m_mode || (s_mode && !status.tvm));
                end
                default: begin
                    result.exc_valid = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* decoder/imm_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module imm_gen import decode_pkg::*; (
    input  logic [31:0] instr,
    input  imm_fmt_e    fmt,
    output logic [31:0] imm
);

    // All formats take their sign from bit 31
    always_comb begin
        case (fmt)
            IMM_I: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            IMM_U: begin
                imm = {instr[31:12], 12'b0};
            end
            IMM_S: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21],
                       1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* common/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    // Major opcodes, all with the low two bits set
    typedef enum logic [6:0] {
        OPCODE_LOAD      = 7'b0000011,
        OPCODE_MISC_MEM  = 7'b0001111,
        OPCODE_OP_IMM    = 7'b0010011,
        OPCODE_AUIPC     = 7'b0010111,
        OPCODE_OP_IMM_32 = 7'b0011011,
        OPCODE_STORE     = 7'b0100011,
        OPCODE_OP        = 7'b0110011,
        OPCODE_LUI       = 7'b0110111,
        OPCODE_OP_32     = 7'b0111011,
        OPCODE_BRANCH    = 7'b1100011,
        OPCODE_JALR      = 7'b1100111,
        OPCODE_JAL       = 7'b1101111,
        OPCODE_SYSTEM    = 7'b1110011
    } opcode_e;

    typedef enum logic [1:0] {
        ALU,
        BRANCH,
        MEM,
        SYSTEM
    } op_type_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        SCC,
        L_XOR,
        L_OR,
        L_AND,
        SHIFT
    } alu_op_e;

    typedef enum logic [2:0] {
        CC_FALSE,
        CC_TRUE,
        CC_EQ,
        CC_NE,
        CC_LT,
        CC_GE,
        CC_LTU,
        CC_GEU
    } cond_e;

    typedef enum logic {
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    typedef enum logic [1:0] {
        FENCE_I,
        ERET,
        WFI,
        SFENCE_VMA
    } sys_op_e;

    typedef enum logic [1:0] {
        PRV_U = 2'd0,
        PRV_S = 2'd1,
        PRV_M = 2'd3
    } prv_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_U,
        IMM_S,
        IMM_B,
        IMM_J,
        IMM_ZERO
    } imm_fmt_e;

    // Trap controls from mstatus
    typedef struct packed {
        logic tsr;
        logic tw;
        logic tvm;
    } status_t;

    typedef struct packed {
        logic        valid;
        logic        interrupt;
        logic [3:0]  cause;
        logic [63:0] tval;
    } exception_t;

    typedef struct packed {
        logic [63:0] pc;
        logic [31:0] instr;
        exception_t  exception;
    } fetched_instr_t;

    typedef struct packed {
        logic       is_sys;
        sys_op_e    sys_op;
        logic       exc_valid;
        logic [3:0] cause;
        logic       tval_zero;
        logic       uses_rs;
    } priv_decode_t;

    typedef struct packed {
        logic [63:0] pc;
        op_type_e    op_type;
        alu_op_e     alu_op;
        logic        shift_left;
        logic        shift_arith;
        cond_e       condition;
        logic        is_32;
        logic        use_pc;
        logic        use_imm;
        logic        adder_use_imm;
        mem_op_e     mem_op;
        logic [1:0]  mem_size;
        logic        mem_zeroext;
        sys_op_e     sys_op;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] immediate;
        exception_t  exception;
    } decoded_instr_t;

    localparam logic [3:0] CAUSE_ILLEGAL    = 4'd2;
    localparam logic [3:0] CAUSE_BREAKPOINT = 4'd3;
    // ECALL from U, S or M adds the privilege level
    localparam logic [3:0] CAUSE_ECALL_BASE = 4'd8;

endpackage

`default_nettype wire
